/* include/regmst_params.svh */
`ifndef REGMST_PARAMS_SVH
`define REGMST_PARAMS_SVH

// bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// external window covers byte addresses below this limit
`define EXT_LIMIT 32'h0000_01C0

// debug block base and number of populated words
`define DBG_BASE 32'h0000_1000
`define DBG_REG_NUM 2'd3

// word offsets inside the debug block
`define OFS_ERR_ADDR 2'd0
`define OFS_TMR_THR 2'd1
`define OFS_ERR_STAT 2'd2

// watchdog threshold after reset
`define TMR_THR_RST 32'd99

`endif

/* design/regmst_apb_pkg.sv */
`default_nettype none

package regmst_apb_pkg;

    // one APB transfer walks through these states in order
    // REQ   issues the request pulse to the targets
    // WAIT  holds until an ack or a watchdog timeout
    // DONE  presents pready with the response
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        WAIT = 2'd2,
        DONE = 2'd3
    } fsm_state_e;

endpackage

`default_nettype wire

/* design/regmst_map_pkg.sv */
`default_nettype none

package regmst_map_pkg;

    // where a decoded transfer goes
    typedef enum logic [1:0] {
        TGT_EXT   = 2'd0,
        TGT_DBG   = 2'd1,
        TGT_EMPTY = 2'd2
    } target_e;

    // debug register selected by the word offset
    typedef enum logic [1:0] {
        REG_ERR_ADDR = 2'd0,
        REG_TMR_THR  = 2'd1,
        REG_ERR_STAT = 2'd2
    } dbg_reg_e;

endpackage

`default_nettype wire

/* design/regmst_apb_fsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "regmst_params.svh"

module regmst_apb_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [`ADDR_WIDTH-1:0]        paddr_i,
    input  logic [`DATA_WIDTH-1:0]        pwdata_i,
    output logic                          pready_o,
    output logic                          pslverr_o,
    output logic [`DATA_WIDTH-1:0]        prdata_o,
    output logic                          req_vld_o,
    output logic                          req_write_o,
    output logic [`ADDR_WIDTH-1:0]        req_addr_o,
    output logic [`DATA_WIDTH-1:0]        req_wdata_o,
    output regmst_map_pkg::target_e       req_target_o,
    input  logic                          rsp_ack_i,
    input  logic [`DATA_WIDTH-1:0]        rsp_rdata_i,
    input  logic                          rsp_err_i,
    input  logic [`DATA_WIDTH-1:0]        tmr_thr_i,
    output logic                          tmout_o,
    output logic                          err_evt_o
);

    regmst_apb_pkg::fsm_state_e state_q;
    regmst_apb_pkg::fsm_state_e state_d;
    regmst_map_pkg::target_e    dec_target;
    logic [`ADDR_WIDTH-1:0]     dbg_ofs;
    logic [`DATA_WIDTH-1:0]     tmr_cnt_q;
    logic                       start;
    logic                       fin;
    logic                       fin_tmout;
    logic                       fin_err;

    assign start = (state_q == regmst_apb_pkg::IDLE) && psel_i && penable_i;
    assign req_vld_o = (state_q == regmst_apb_pkg::REQ);

    // address map is only sampled at the start of a transfer
    always_comb begin
        dbg_ofs = paddr_i - `DBG_BASE;
        if (paddr_i < `EXT_LIMIT) begin
            dec_target = regmst_map_pkg::TGT_EXT;
        end else if (paddr_i >= `DBG_BASE && dbg_ofs[`ADDR_WIDTH-1:4] == '0 &&
                     dbg_ofs[3:2] < `DBG_REG_NUM) begin
            dec_target = regmst_map_pkg::TGT_DBG;
        end else begin
            dec_target = regmst_map_pkg::TGT_EMPTY;
        end
    end

    always_comb begin
        state_d   = state_q;
        fin       = 1'b0;
        fin_tmout = 1'b0;
        case (state_q)
            regmst_apb_pkg::IDLE: begin
                if (start) begin
                    state_d = regmst_apb_pkg::REQ;
                end
            end
            regmst_apb_pkg::REQ: begin
                state_d = regmst_apb_pkg::WAIT;
            end
            regmst_apb_pkg::WAIT: begin
                // an ack in the threshold cycle still wins
                if (rsp_ack_i) begin
                    state_d = regmst_apb_pkg::DONE;
                    fin     = 1'b1;
                end else if (tmr_cnt_q == tmr_thr_i) begin
                    state_d   = regmst_apb_pkg::DONE;
                    fin       = 1'b1;
                    fin_tmout = 1'b1;
                end
            end
            default: begin
                state_d = regmst_apb_pkg::IDLE;
            end
        endcase
    end

    assign fin_err = fin_tmout || (fin && rsp_err_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= regmst_apb_pkg::IDLE;
            req_target_o <= regmst_map_pkg::TGT_EMPTY;
            tmr_cnt_q    <= '0;
            pready_o     <= 1'b0;
            pslverr_o    <= 1'b0;
            prdata_o     <= '0;
            tmout_o      <= 1'b0;
            err_evt_o    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start) begin
                req_target_o <= dec_target;
            end
            // watchdog only runs while waiting for an answer
            if (state_q == regmst_apb_pkg::WAIT && !fin) begin
                tmr_cnt_q <= tmr_cnt_q + 1'b1;
            end else begin
                tmr_cnt_q <= '0;
            end
            pready_o  <= fin;
            pslverr_o <= fin_err;
            prdata_o  <= fin ? rsp_rdata_i : '0;
            tmout_o   <= fin_tmout;
            err_evt_o <= fin_err;
        end
    end

    // request payload held from start until back in IDLE
    always_ff @(posedge clk) begin
        if (start) begin
            req_write_o <= pwrite_i;
            req_addr_o  <= paddr_i;
            req_wdata_o <= pwdata_i;
        end
    end

endmodule

`default_nettype wire

/* design/regmst_dbg_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "regmst_params.svh"

module regmst_dbg_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_vld_i,
    input  logic                          req_write_i,
    input  logic [`ADDR_WIDTH-1:0]        req_addr_i,
    input  logic [`DATA_WIDTH-1:0]        req_wdata_i,
    input  regmst_map_pkg::target_e       req_target_i,
    input  logic                          tmout_i,
    input  logic                          err_evt_i,
    output logic                          ack_o,
    output logic [`DATA_WIDTH-1:0]        rdata_o,
    output logic                          err_o,
    output logic [`DATA_WIDTH-1:0]        tmr_thr_o,
    output logic                          soft_rst_o
);

    regmst_map_pkg::dbg_reg_e reg_idx;
    logic [`ADDR_WIDTH-1:0]   err_addr_q;
    logic [`DATA_WIDTH-1:0]   tmr_thr_q;
    logic                     soft_rst_q;
    logic                     err_occur_q;
    logic                     err_acc_type_q;
    logic [`DATA_WIDTH-1:0]   reg_rdata;
    logic                     sel_dbg;
    logic                     sel_empty;
    logic                     wr_thr;
    logic                     wr_stat;

    // word offset to register
    always_comb begin
        case (req_addr_i[3:2])
            `OFS_TMR_THR:  reg_idx = regmst_map_pkg::REG_TMR_THR;
            `OFS_ERR_STAT: reg_idx = regmst_map_pkg::REG_ERR_STAT;
            default:       reg_idx = regmst_map_pkg::REG_ERR_ADDR;
        endcase
    end

    always_comb begin
        reg_rdata = '0;
        case (reg_idx)
            regmst_map_pkg::REG_ERR_ADDR: reg_rdata = err_addr_q;
            regmst_map_pkg::REG_TMR_THR:  reg_rdata = tmr_thr_q;
            regmst_map_pkg::REG_ERR_STAT: reg_rdata[2:0] = {err_acc_type_q, err_occur_q,
                                                           soft_rst_q};
            default:                      reg_rdata = '0;
        endcase
    end

    assign sel_dbg   = req_vld_i && (req_target_i == regmst_map_pkg::TGT_DBG);
    assign sel_empty = req_vld_i && (req_target_i == regmst_map_pkg::TGT_EMPTY);
    // ERR_ADDR has no write strobe at all
    assign wr_thr    = sel_dbg && req_write_i && (reg_idx == regmst_map_pkg::REG_TMR_THR);
    assign wr_stat   = sel_dbg && req_write_i && (reg_idx == regmst_map_pkg::REG_ERR_STAT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_addr_q     <= '0;
            tmr_thr_q      <= `TMR_THR_RST;
            soft_rst_q     <= 1'b0;
            err_occur_q    <= 1'b0;
            err_acc_type_q <= 1'b0;
            ack_o          <= 1'b0;
            err_o          <= 1'b0;
            rdata_o        <= '0;
        end else begin
            if (wr_thr) begin
                tmr_thr_q <= req_wdata_i;
            end
            if (wr_stat) begin
                soft_rst_q <= req_wdata_i[0];
            end
            // timeout sets ERR_OCCUR and software may clear it
            if (tmout_i) begin
                err_occur_q <= 1'b1;
                err_addr_q  <= req_addr_i;
            end else if (wr_stat) begin
                err_occur_q <= req_wdata_i[1];
            end
            if (err_evt_i) begin
                err_acc_type_q <= req_write_i;
            end
            // answer one cycle after the request
            ack_o   <= sel_dbg || sel_empty;
            err_o   <= sel_empty;
            rdata_o <= (sel_dbg && !req_write_i) ? reg_rdata : '0;
        end
    end

    assign tmr_thr_o  = tmr_thr_q;
    assign soft_rst_o = soft_rst_q;

endmodule

`default_nettype wire

/* design/regmst_ext_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "regmst_params.svh"

module regmst_ext_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_vld_i,
    input  logic                          req_write_i,
    input  logic [`ADDR_WIDTH-1:0]        req_addr_i,
    input  logic [`DATA_WIDTH-1:0]        req_wdata_i,
    input  regmst_map_pkg::target_e       req_target_i,
    output logic                          ext_req_vld_o,
    output logic                          ext_wr_en_o,
    output logic                          ext_rd_en_o,
    output logic [`ADDR_WIDTH-1:0]        ext_addr_o,
    output logic [`DATA_WIDTH-1:0]        ext_wr_data_o,
    input  logic                          ext_ack_vld_i,
    input  logic                          ext_err_i,
    input  logic [`DATA_WIDTH-1:0]        ext_rd_data_i,
    output logic                          ack_o,
    output logic [`DATA_WIDTH-1:0]        rdata_o,
    output logic                          err_o
);

    logic is_ext;
    logic ext_sel;

    assign is_ext  = (req_target_i == regmst_map_pkg::TGT_EXT);
    assign ext_sel = req_vld_i && is_ext;

    // address and data stay quiet unless the transfer is external
    assign ext_addr_o    = is_ext ? req_addr_i : '0;
    assign ext_wr_data_o = is_ext ? req_wdata_i : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_req_vld_o <= 1'b0;
            ext_wr_en_o   <= 1'b0;
            ext_rd_en_o   <= 1'b0;
            ack_o         <= 1'b0;
            err_o         <= 1'b0;
            rdata_o       <= '0;
        end else begin
            ext_req_vld_o <= ext_sel;
            ext_wr_en_o   <= ext_sel && req_write_i;
            ext_rd_en_o   <= ext_sel && !req_write_i;
            // answers only count while an external transfer is open
            ack_o         <= ext_ack_vld_i && is_ext;
            err_o         <= ext_ack_vld_i && is_ext && ext_err_i;
            rdata_o       <= (ext_ack_vld_i && is_ext) ? ext_rd_data_i : '0;
        end
    end

endmodule

`default_nettype wire

/* design/regmst_resp_merge.sv */
`timescale 1ns/1ps
`default_nettype none
`include "regmst_params.svh"

module regmst_resp_merge (
    input  logic                          dbg_ack_i,
    input  logic [`DATA_WIDTH-1:0]        dbg_rdata_i,
    input  logic                          dbg_err_i,
    input  logic                          ext_ack_i,
    input  logic [`DATA_WIDTH-1:0]        ext_rdata_i,
    input  logic                          ext_err_i,
    output logic                          rsp_ack_o,
    output logic [`DATA_WIDTH-1:0]        rsp_rdata_o,
    output logic                          rsp_err_o
);

    assign rsp_ack_o = dbg_ack_i || ext_ack_i;

    // an error flag without its own ack is ignored
    assign rsp_err_o = (dbg_ack_i && dbg_err_i) || (ext_ack_i && ext_err_i);

    // only one side acks a given request
    always_comb begin
        if (dbg_ack_i) begin
            rsp_rdata_o = dbg_rdata_i;
        end else if (ext_ack_i) begin
            rsp_rdata_o = ext_rdata_i;
        end else begin
            rsp_rdata_o = '0;
        end
    end

endmodule

`default_nettype wire

/* design/regmst_root_map.sv */
`timescale 1ns/1ps
`default_nettype none
`include "regmst_params.svh"

module regmst_root_map (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [`ADDR_WIDTH-1:0]        paddr_i,
    input  logic [`DATA_WIDTH-1:0]        pwdata_i,
    output logic                          pready_o,
    output logic                          pslverr_o,
    output logic [`DATA_WIDTH-1:0]        prdata_o,
    output logic                          ext_req_vld_o,
    output logic                          ext_wr_en_o,
    output logic                          ext_rd_en_o,
    output logic [`ADDR_WIDTH-1:0]        ext_addr_o,
    output logic [`DATA_WIDTH-1:0]        ext_wr_data_o,
    input  logic                          ext_ack_vld_i,
    input  logic                          ext_err_i,
    input  logic [`DATA_WIDTH-1:0]        ext_rd_data_i,
    output logic                          ext_soft_rst_o
);

    // request from the state machine
    logic                    req_vld;
    logic                    req_write;
    logic [`ADDR_WIDTH-1:0]  req_addr;
    logic [`DATA_WIDTH-1:0]  req_wdata;
    regmst_map_pkg::target_e req_target;

    // answers from both sides and the merged response
    logic                    dbg_ack;
    logic [`DATA_WIDTH-1:0]  dbg_rdata;
    logic                    dbg_err;
    logic                    ext_ack;
    logic [`DATA_WIDTH-1:0]  ext_rdata;
    logic                    ext_err;
    logic                    rsp_ack;
    logic [`DATA_WIDTH-1:0]  rsp_rdata;
    logic                    rsp_err;

    // watchdog and error events
    logic [`DATA_WIDTH-1:0]  tmr_thr;
    logic                    tmout;
    logic                    err_evt;

    regmst_apb_fsm u_regmst_apb_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .prdata_o     (prdata_o),
        .req_vld_o    (req_vld),
        .req_write_o  (req_write),
        .req_addr_o   (req_addr),
        .req_wdata_o  (req_wdata),
        .req_target_o (req_target),
        .rsp_ack_i    (rsp_ack),
        .rsp_rdata_i  (rsp_rdata),
        .rsp_err_i    (rsp_err),
        .tmr_thr_i    (tmr_thr),
        .tmout_o      (tmout),
        .err_evt_o    (err_evt)
    );

    regmst_dbg_regs u_regmst_dbg_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_vld_i    (req_vld),
        .req_write_i  (req_write),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .req_target_i (req_target),
        .tmout_i      (tmout),
        .err_evt_i    (err_evt),
        .ack_o        (dbg_ack),
        .rdata_o      (dbg_rdata),
        .err_o        (dbg_err),
        .tmr_thr_o    (tmr_thr),
        .soft_rst_o   (ext_soft_rst_o)
    );

    regmst_ext_port u_regmst_ext_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_vld_i     (req_vld),
        .req_write_i   (req_write),
        .req_addr_i    (req_addr),
        .req_wdata_i   (req_wdata),
        .req_target_i  (req_target),
        .ext_req_vld_o (ext_req_vld_o),
        .ext_wr_en_o   (ext_wr_en_o),
        .ext_rd_en_o   (ext_rd_en_o),
        .ext_addr_o    (ext_addr_o),
        .ext_wr_data_o (ext_wr_data_o),
        .ext_ack_vld_i (ext_ack_vld_i),
        .ext_err_i     (ext_err_i),
        .ext_rd_data_i (ext_rd_data_i),
        .ack_o         (ext_ack),
        .rdata_o       (ext_rdata),
        .err_o         (ext_err)
    );

    regmst_resp_merge u_regmst_resp_merge (
        .dbg_ack_i   (dbg_ack),
        .dbg_rdata_i (dbg_rdata),
        .dbg_err_i   (dbg_err),
        .ext_ack_i   (ext_ack),
        .ext_rdata_i (ext_rdata),
        .ext_err_i   (ext_err),
        .rsp_ack_o   (rsp_ack),
        .rsp_rdata_o (rsp_rdata),
        .rsp_err_o   (rsp_err)
    );

endmodule

`default_nettype wire

/* bench/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // release lands on a falling edge away from the DUT's rising edge
    initial begin
        rst_n_o = 1'b0;
        #(PERIOD_NS * RST_CYCLES) rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_regmst.sv */
`timescale 1ns/1ps
`default_nettype none
`include "regmst_params.svh"

module tb_regmst;

    localparam int          MAX_VEC       = 64;
    localparam int          NO_ANSWER     = 255;
    localparam logic [31:0] LFSR_SEED     = 32'h8d43b2cf;
    localparam logic [31:0] ERR_STAT_ADDR = `DBG_BASE + 4 * `OFS_ERR_STAT;

    wire                     clk;
    wire                     rst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`ADDR_WIDTH-1:0]  paddr;
    logic [`DATA_WIDTH-1:0]  pwdata;
    wire                     pready;
    wire                     pslverr;
    wire  [`DATA_WIDTH-1:0]  prdata;
    wire                     ext_req_vld;
    wire                     ext_wr_en;
    wire                     ext_rd_en;
    wire  [`ADDR_WIDTH-1:0]  ext_addr;
    wire  [`DATA_WIDTH-1:0]  ext_wr_data;
    logic                    ext_ack_vld;
    logic                    ext_err;
    logic [`DATA_WIDTH-1:0]  ext_rd_data;
    wire                     ext_soft_rst;

    // one entry per transfer from the vector file
    logic                    vec_write [MAX_VEC];
    logic [`ADDR_WIDTH-1:0]  vec_addr [MAX_VEC];
    logic [`DATA_WIDTH-1:0]  vec_wdata [MAX_VEC];
    int                      vec_delay [MAX_VEC];
    logic                    vec_ext_err [MAX_VEC];
    logic [`DATA_WIDTH-1:0]  vec_ext_rdata [MAX_VEC];
    logic [`DATA_WIDTH-1:0]  vec_exp_rdata [MAX_VEC];
    logic                    vec_exp_err [MAX_VEC];
    int                      vec_count;

    // external responder setup and what it saw
    int                      rsp_delay;
    logic                    rsp_err;
    logic [`DATA_WIDTH-1:0]  rsp_rdata;
    int                      ext_req_cnt;
    logic [`ADDR_WIDTH-1:0]  seen_addr;
    logic [`DATA_WIDTH-1:0]  seen_wdata;
    logic                    seen_wr_en;
    logic                    seen_rd_en;

    logic [31:0]             lfsr;
    logic                    soft_rst_model;
    int                      errors;
    int                      cycles = 0;
    int                      cycle_limit = 0;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    regmst_root_map u_regmst_root_map (
        .clk            (clk),
        .rst_n          (rst_n),
        .psel_i         (psel),
        .penable_i      (penable),
        .pwrite_i       (pwrite),
        .paddr_i        (paddr),
        .pwdata_i       (pwdata),
        .pready_o       (pready),
        .pslverr_o      (pslverr),
        .prdata_o       (prdata),
        .ext_req_vld_o  (ext_req_vld),
        .ext_wr_en_o    (ext_wr_en),
        .ext_rd_en_o    (ext_rd_en),
        .ext_addr_o     (ext_addr),
        .ext_wr_data_o  (ext_wr_data),
        .ext_ack_vld_i  (ext_ack_vld),
        .ext_err_i      (ext_err),
        .ext_rd_data_i  (ext_rd_data),
        .ext_soft_rst_o (ext_soft_rst)
    );

    // fibonacci form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr   = lfsr_next(lfsr);
            val[i] = lfsr[0];
        end
    endtask

    task automatic check_true(input logic ok, input string msg);
        assert (ok) else begin
            $display("ERROR at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        int          dl;
        int          e;
        logic [31:0] rd;
        logic [31:0] xr;
        int          xe;
        vec_count = 0;
        fd = $fopen("bench/regmst_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/regmst_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd) && vec_count < MAX_VEC) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %d %d %h %h %d", op, a, d, dl, e, rd, xr, xe);
                    if (n == 8) begin
                        vec_write[vec_count]     = (op == "W");
                        vec_addr[vec_count]      = a;
                        vec_wdata[vec_count]     = d;
                        vec_delay[vec_count]     = dl;
                        vec_ext_err[vec_count]   = (e != 0);
                        vec_ext_rdata[vec_count] = rd;
                        vec_exp_rdata[vec_count] = xr;
                        vec_exp_err[vec_count]   = (xe != 0);
                        vec_count++;
                    end else begin
                        $display("vector line could not be parsed: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (vec_count == 0) begin
            $display("no transfers were read from the vector file");
            errors++;
        end
    endtask

    // drives on falling edges and counts falling edges from the access phase to pready
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err, output int wait_cycles);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable     = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!pready);
        rdata   = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // external register window model
    initial begin : ext_responder
        ext_ack_vld = 1'b0;
        ext_err     = 1'b0;
        ext_rd_data = '0;
        ext_req_cnt = 0;
        seen_addr   = '0;
        seen_wdata  = '0;
        seen_wr_en  = 1'b0;
        seen_rd_en  = 1'b0;
        forever begin
            @(negedge clk);
            if (ext_req_vld) begin
                ext_req_cnt++;
                seen_addr  = ext_addr;
                seen_wdata = ext_wr_data;
                seen_wr_en = ext_wr_en;
                seen_rd_en = ext_rd_en;
                if (rsp_delay != NO_ANSWER) begin
                    repeat (rsp_delay) @(negedge clk);
                    ext_ack_vld = 1'b1;
                    ext_err     = rsp_err;
                    ext_rd_data = rsp_rdata;
                    @(negedge clk);
                    ext_ack_vld = 1'b0;
                    ext_err     = 1'b0;
                    ext_rd_data = '0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run stopped after %0d cycles, the transfers did not finish in time", cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial begin : main
        logic [31:0] wdata;
        logic [31:0] pad;
        logic [31:0] rdata;
        logic        err;
        logic        is_ext;
        int          lat;
        int          reqs_before;
        int          errors_before;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        rsp_delay      = NO_ANSWER;
        rsp_err        = 1'b0;
        rsp_rdata      = '0;
        errors         = 0;
        lfsr           = LFSR_SEED;
        soft_rst_model = 1'b0;
        load_vectors();
        cycle_limit = vec_count * (`TMR_THR_RST + 10);

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_true(!pready && !pslverr, "pready or pslverr high after reset");
        check_true(!ext_req_vld && !ext_wr_en && !ext_rd_en, "external strobe high after reset");
        check_true(!ext_soft_rst, "ext_soft_rst high after reset");

        for (int i = 0; i < vec_count; i++) begin
            errors_before = errors;
            is_ext        = (vec_addr[i] < `EXT_LIMIT);
            wdata         = vec_wdata[i];
            // unused data bits get random fill
            if (!vec_write[i]) begin
                random_bits(32, wdata);
            end else if (vec_addr[i] == ERR_STAT_ADDR) begin
                random_bits(29, pad);
                wdata          = {pad[28:0], vec_wdata[i][2:0]};
                soft_rst_model = wdata[0];
            end
            rsp_delay   = vec_delay[i];
            rsp_err     = vec_ext_err[i];
            rsp_rdata   = vec_ext_rdata[i];
            reqs_before = ext_req_cnt;

            apb_transfer(vec_write[i], vec_addr[i], wdata, rdata, err, lat);

            check_true(rdata === vec_exp_rdata[i],
                       $sformatf("test %0d prdata %h, expected %h", i, rdata, vec_exp_rdata[i]));
            check_true(err === vec_exp_err[i],
                       $sformatf("test %0d pslverr %b, expected %b", i, err, vec_exp_err[i]));
            check_true(ext_soft_rst === soft_rst_model,
                       $sformatf("test %0d ext_soft_rst %b, expected %b", i, ext_soft_rst,
                                 soft_rst_model));
            if (is_ext) begin
                check_true(ext_req_cnt - reqs_before == 1,
                           $sformatf("test %0d saw %0d external requests, expected 1", i,
                                     ext_req_cnt - reqs_before));
                check_true(seen_addr === vec_addr[i],
                           $sformatf("test %0d ext_addr %h, expected %h", i, seen_addr,
                                     vec_addr[i]));
                check_true(seen_wr_en === vec_write[i] && seen_rd_en === !vec_write[i],
                           $sformatf("test %0d wr_en %b rd_en %b for write flag %b", i,
                                     seen_wr_en, seen_rd_en, vec_write[i]));
                if (vec_write[i]) begin
                    check_true(seen_wdata === wdata,
                               $sformatf("test %0d ext_wr_data %h, expected %h", i, seen_wdata,
                                         wdata));
                end
            end else begin
                check_true(ext_req_cnt == reqs_before,
                           $sformatf("test %0d issued an external request", i));
                check_true(lat == 3,
                           $sformatf("test %0d pready after %0d cycles, expected 3", i, lat));
                check_true(ext_addr === '0 && ext_wr_data === '0,
                           $sformatf("test %0d ext_addr %h ext_wr_data %h, expected zero", i,
                                     ext_addr, ext_wr_data));
            end
            $display("test %0d %s %h: %s", i, vec_write[i] ? "W" : "R", vec_addr[i],
                     (errors == errors_before) ? "ok" : "failed");
        end

        $display("%0d tests run, %0d errors", vec_count, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/regmst_vectors.txt */
# op addr wdata ext_delay ext_err ext_rdata exp_prdata exp_pslverr
# op is R or W, ext_delay in decimal cycles (255 = no answer), flags 0 or 1, rest hex
R 00001004 00000000 0 0 00000000 00000063 0
R 00001008 00000000 0 0 00000000 00000000 0
W 00001004 00000040 0 0 00000000 00000000 0
R 00001004 00000000 0 0 00000000 00000040 0
W 00001000 deadbeef 0 0 00000000 00000000 0
R 00001000 00000000 0 0 00000000 00000000 0
W 00001008 00000005 0 0 00000000 00000000 0
R 00001008 00000000 0 0 00000000 00000001 0
W 00001008 00000000 0 0 00000000 00000000 0
W 00000040 12345678 3 0 00000000 00000000 0
R 00000044 00000000 5 0 cafef00d cafef00d 0
R 000001bc 00000000 0 1 00000000 00000000 1
W 0000100c 00000055 0 0 00000000 00000000 1
R 00001008 00000000 0 0 00000000 00000004 0
R 00002000 00000000 0 0 00000000 00000000 1
R 000001c0 00000000 0 0 00000000 00000000 1
R 00001008 00000000 0 0 00000000 00000000 0
W 00001004 00000005 0 0 00000000 00000000 0
R 00000080 00000000 255 0 00000000 00000000 1
R 00001000 00000000 0 0 00000000 00000080 0
R 00001008 00000000 0 0 00000000 00000002 0
W 00001008 00000000 0 0 00000000 00000000 0
R 00001008 00000000 0 0 00000000 00000000 0
W 00000100 0badf00d 2 0 00000000 00000000 0

/* vlog.f */
+incdir+include
design/regmst_apb_pkg.sv
design/regmst_map_pkg.sv
design/regmst_apb_fsm.sv
design/regmst_dbg_regs.sv
design/regmst_ext_port.sv
design/regmst_resp_merge.sv
design/regmst_root_map.sv
bench/tb_clkgen.sv
bench/tb_regmst.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the regmst testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_regmst -o tb_regmst > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/tb_regmst > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Errors found" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "No errors" "$SIM_LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "PASS"
exit 0
